// ==== compile.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
operand_forward.sv
dispatch.sv
exec_pipe.sv
issue_top.sv
tb_issue_top.sv

// ==== tb_issue_top.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module tb_issue_top;

    import isa_pkg::*;

    localparam int SEED     = 91361;
    localparam int N_RANDOM = 200;
    localparam int N_BRANCH = 24;

    // One decoded instruction with gap idle cycles before it
    // During the gap ctrl 1 stalls and ctrl 2 flushes
    typedef struct {
        alu_op_e op;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [4:0] rd;
        logic rjv;
        logic rkv;
        logic rdv;
        logic use_imm;
        logic [31:0] imm;
        int gap;
        int ctrl;
        string name;
    } inst_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic stall_i = 1'b0;
    logic flush_i = 1'b0;
    logic [1:0] valid_i = '0;
    alu_op_e [1:0] op_i;
    logic [1:0][4:0] rj_i = '0;
    logic [1:0][4:0] rk_i = '0;
    logic [1:0][4:0] rd_i = '0;
    logic [1:0] rj_valid_i = '0;
    logic [1:0] rk_valid_i = '0;
    logic [1:0] rd_valid_i = '0;
    logic [1:0] use_imm_i = '0;
    logic [1:0][31:0] imm_i = '0;
    logic [1:0] accept_o;
    logic [1:0] wb_valid_o;
    logic [1:0] wb_we_o;
    logic [1:0] wb_taken_o;
    logic [1:0][4:0] wb_rd_o;
    logic [1:0][31:0] wb_data_o;

    logic [31:0] lfsr = SEED;
    logic [31:0] mreg [32];
    inst_t pend[$];
    string lane_name [2];
    logic [4:0] exp_rd[$];
    logic exp_we[$];
    logic exp_taken[$];
    logic [31:0] exp_data[$];
    string exp_name[$];
    // Entries accepted at the last unstalled edge and undone by a flush
    int prev_pushed = 0;
    logic [4:0] undo_rd [2];
    logic [31:0] undo_val [2];
    logic undo_we [2];
    int cycles = 0;
    int limit = 100000;
    bit seen_accept = 1'b0;

    issue_top issue_top_inst (.*);

    always #2 clk = ~clk;

    task automatic fail_stop();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_val(string test, string what, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s expected %h actual %h", test, what, exp, act);
            fail_stop();
        end
    endtask

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA300_0000 : lfsr >> 1;
        end
        return v;
    endfunction

    // Reference ALU giving data and branch outcome from architectural operands
    function automatic void ref_exec(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                     logic [31:0] breg, output logic [31:0] data,
                                     output logic taken, output logic br);
        data = '0;
        taken = 1'b0;
        br = 1'b1;
        case (op)
            OP_BEQ:  taken = a == breg;
            OP_BNE:  taken = a != breg;
            OP_BLT:  taken = $signed(a) < $signed(breg);
            OP_BGE:  taken = $signed(a) >= $signed(breg);
            OP_BLTU: taken = a < breg;
            OP_BGEU: taken = a >= breg;
            default: begin
                br = 1'b0;
                case (op)
                    OP_ADD:  data = a + b;
                    OP_SUB:  data = a - b;
                    OP_AND:  data = a & b;
                    OP_OR:   data = a | b;
                    OP_XOR:  data = a ^ b;
                    OP_SLL:  data = a << b[4:0];
                    OP_SRL:  data = a >> b[4:0];
                    OP_SLT:  data = {31'b0, $signed(a) < $signed(b)};
                    default: data = {31'b0, a < b};
                endcase
            end
        endcase
    endfunction

    function automatic inst_t rand_inst(string name);
        inst_t t;
        t.op = alu_op_e'(rand_bits(4) % 15);
        t.rj = rand_bits(5);
        t.rk = rand_bits(5);
        t.rd = rand_bits(5);
        if (t.rd == 0) t.rd = 5'd1;
        t.rjv = 1'b1;
        t.rkv = 1'b1;
        t.rdv = t.op < OP_BEQ;
        t.use_imm = rand_bits(1);
        t.imm = rand_bits(32);
        t.gap = 0;
        t.ctrl = 0;
        t.name = name;
        return t;
    endfunction

    task automatic set_lane(int l, inst_t t);
        valid_i[l] = 1'b1;
        op_i[l] = t.op;
        rj_i[l] = t.rj;
        rk_i[l] = t.rk;
        rd_i[l] = t.rd;
        rj_valid_i[l] = t.rjv;
        rk_valid_i[l] = t.rkv;
        rd_valid_i[l] = t.rdv;
        use_imm_i[l] = t.use_imm;
        imm_i[l] = t.imm;
        lane_name[l] = t.name;
    endtask

    // Writeback comparison and the reference model
    always @(posedge clk) begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] breg;
        logic [31:0] data;
        logic taken;
        logic br;
        logic we;
        int pushed;
        if (rst_n) begin
            cycles++;
            if (cycles >= limit) begin
                $display("Timeout: the run did not finish within %0d cycles", limit);
                fail_stop();
            end
            if (stall_i || !seen_accept) check_val("idle", "wb_valid", '0, wb_valid_o);
            for (int l = 0; l < 2; l++) begin
                if (wb_valid_o[l]) begin
                    assert (exp_rd.size() > 0) else begin
                        $display("Writeback on lane %0d with no instruction expected", l);
                        fail_stop();
                    end
                    check_val(exp_name[0], "rd", exp_rd[0], wb_rd_o[l]);
                    check_val(exp_name[0], "we", exp_we[0], wb_we_o[l]);
                    check_val(exp_name[0], "data", exp_data[0], wb_data_o[l]);
                    check_val(exp_name[0], "taken", exp_taken[0], wb_taken_o[l]);
                    void'(exp_rd.pop_front());
                    void'(exp_we.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_taken.pop_front());
                    void'(exp_name.pop_front());
                end
            end
            // A flush drops the pair that sat in the dispatch register
            if (flush_i && !stall_i) begin
                for (int k = prev_pushed - 1; k >= 0; k--) begin
                    if (undo_we[k]) mreg[undo_rd[k]] = undo_val[k];
                    void'(exp_rd.pop_back());
                    void'(exp_we.pop_back());
                    void'(exp_data.pop_back());
                    void'(exp_taken.pop_back());
                    void'(exp_name.pop_back());
                end
            end
            pushed = 0;
            for (int l = 0; l < 2; l++) begin
                if (accept_o[l]) begin
                    seen_accept = 1'b1;
                    a = rj_valid_i[l] ? mreg[rj_i[l]] : '0;
                    breg = rk_valid_i[l] ? mreg[rk_i[l]] : '0;
                    b = use_imm_i[l] ? imm_i[l] : breg;
                    ref_exec(op_i[l], a, b, breg, data, taken, br);
                    we = !br && rd_valid_i[l] && rd_i[l] != 0;
                    exp_rd.push_back(rd_valid_i[l] ? rd_i[l] : 5'd0);
                    exp_we.push_back(we);
                    exp_data.push_back(data);
                    exp_taken.push_back(taken);
                    exp_name.push_back(lane_name[l]);
                    undo_rd[pushed] = rd_i[l];
                    undo_val[pushed] = mreg[rd_i[l]];
                    undo_we[pushed] = we;
                    pushed++;
                    if (we) mreg[rd_i[l]] = data;
                end
            end
            // The dispatch register keeps its pair through a stall
            if (!stall_i) prev_pushed = pushed;
        end
    end

    initial begin
        inst_t t;
        inst_t p0;
        inst_t p1;
        logic [1:0] exp_acc;
        int total;
        for (int r = 0; r < 32; r++) mreg[r] = '0;
        op_i = {OP_ADD, OP_ADD};
        for (int i = 0; i < N_RANDOM; i++) pend.push_back(rand_inst("random_pairs"));
        // Chains through rd 7 spaced 1, 2 and 3 cycles apart
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < 8; i++) begin
                t = rand_inst($sformatf("chain_dist%0d", d));
                t.op = (i % 2) ? OP_SUB : OP_ADD;
                t.rdv = 1'b1;
                t.rd = 5'd7;
                t.rj = 5'd7;
                t.gap = (i == 0) ? 0 : d - 1;
                pend.push_back(t);
            end
        end
        // The idle gap puts the producer on lane 0 of the pair
        for (int i = 0; i < 6; i++) begin
            t = rand_inst("pair_dependency");
            t.op = OP_XOR;
            t.rdv = 1'b1;
            t.gap = 1;
            pend.push_back(t);
            t = rand_inst("pair_dependency");
            t.op = OP_OR;
            t.rdv = 1'b1;
            t.rk = pend[pend.size()-1].rd;
            t.use_imm = 1'b0;
            t.gap = 0;
            pend.push_back(t);
        end
        // Both lanes write rd 9, then a reader 1, 2 or 3 cycles later
        for (int i = 0; i < 3; i++) begin
            t = rand_inst("same_rd");
            t.op = OP_ADD;
            t.rdv = 1'b1;
            t.rd = 5'd9;
            t.rj = t.rj & 5'h7;
            t.rk = t.rk & 5'h7;
            t.use_imm = 1'b1;
            t.gap = 1;
            pend.push_back(t);
            t.op = OP_XOR;
            t.imm = rand_bits(32);
            t.gap = 0;
            pend.push_back(t);
            t = rand_inst("same_rd");
            t.op = OP_ADD;
            t.rdv = 1'b1;
            t.rj = 5'd9;
            t.gap = i;
            pend.push_back(t);
        end
        for (int i = 0; i < N_BRANCH; i++) begin
            t = rand_inst("branch");
            t.op = alu_op_e'(OP_BEQ + rand_bits(3) % 6);
            t.rdv = 1'b0;
            if (i % 2) t.rk = t.rj;
            pend.push_back(t);
        end
        for (int i = 0; i < 12; i++) begin
            t = rand_inst("stall_flush");
            if (i == 4) begin
                t.gap = 3;
                t.ctrl = 1;
            end
            if (i == 8) begin
                t.gap = 2;
                t.ctrl = 2;
            end
            pend.push_back(t);
        end
        total = 0;
        foreach (pend[i]) total += 1 + pend[i].gap;
        limit = total * 4 + 100;

        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        for (int r = 0; r < 32; r++) begin
            check_val("reset", $sformatf("reg %0d", r), '0,
                      issue_top_inst.reg_file_inst.regs[r]);
        end

        while (pend.size() > 0) begin
            p0 = pend[0];
            valid_i = '0;
            stall_i = 1'b0;
            flush_i = 1'b0;
            exp_acc = 2'b00;
            if (p0.gap > 0 && p0.ctrl == 0) begin
                // Idle cycle with nothing presented
            end else begin
                set_lane(0, p0);
                if (pend.size() > 1 && pend[1].gap == 0) begin
                    p1 = pend[1];
                    set_lane(1, p1);
                end
                stall_i = p0.gap > 0 && p0.ctrl == 1;
                flush_i = p0.gap > 0 && p0.ctrl == 2;
                if (p0.gap == 0) begin
                    exp_acc[0] = 1'b1;
                    exp_acc[1] = valid_i[1] && !(p0.rdv &&
                                 ((p1.rjv && p1.rj == p0.rd) || (p1.rkv && p1.rk == p0.rd)));
                end
            end
            @(posedge clk);
            check_val(p0.name, "accept", exp_acc, accept_o);
            if (p0.gap > 0) begin
                pend[0].gap = p0.gap - 1;
            end else begin
                if (accept_o[0]) void'(pend.pop_front());
                if (accept_o[1]) void'(pend.pop_front());
            end
            #0.5;
        end
        valid_i = '0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        while (exp_rd.size() > 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== issue_top.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module issue_top (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          stall_i,
    input  logic                                          flush_i,
    input  logic [`ISSUE_LANES-1:0]                       valid_i,
    input  isa_pkg::alu_op_e [`ISSUE_LANES-1:0]           op_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    rj_i,
    input  logic [`ISSUE_LANES-1:0]                       rj_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    rk_i,
    input  logic [`ISSUE_LANES-1:0]                       rk_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    rd_i,
    input  logic [`ISSUE_LANES-1:0]                       rd_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    imm_i,
    input  logic [`ISSUE_LANES-1:0]                       use_imm_i,
    output logic [`ISSUE_LANES-1:0]                       accept_o,
    output logic [`ISSUE_LANES-1:0]                       wb_valid_o,
    output logic [`ISSUE_LANES-1:0]                       wb_we_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    wb_rd_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    wb_data_o,
    output logic [`ISSUE_LANES-1:0]                       wb_taken_o
);

    import isa_pkg::*;

    logic [2*`ISSUE_LANES-1:0]                     rf_rd_en;
    logic [2*`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]  rf_rd_addr;
    logic [2*`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]  rf_rd_data;
    logic [`ISSUE_LANES-1:0]                       ex_fwd_valid;
    logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    ex_fwd_addr;
    logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_fwd_data;
    logic [`ISSUE_LANES-1:0]                       ex_valid;
    alu_op_e [`ISSUE_LANES-1:0]                    ex_op;
    logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    ex_rd;
    logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_opa;
    logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_opb;
    logic [`ISSUE_LANES-1:0][`ISSUE_CMP_W-1:0]     ex_cmp;

    dispatch dispatch_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (stall_i),
        .flush_i         (flush_i),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .rj_i            (rj_i),
        .rj_valid_i      (rj_valid_i),
        .rk_i            (rk_i),
        .rk_valid_i      (rk_valid_i),
        .rd_i            (rd_i),
        .rd_valid_i      (rd_valid_i),
        .imm_i           (imm_i),
        .use_imm_i       (use_imm_i),
        .accept_o        (accept_o),
        .rf_rd_en_o      (rf_rd_en),
        .rf_rd_addr_o    (rf_rd_addr),
        .rf_rd_data_i    (rf_rd_data),
        .ex_fwd_valid_i  (ex_fwd_valid),
        .ex_fwd_addr_i   (ex_fwd_addr),
        .ex_fwd_data_i   (ex_fwd_data),
        .mem_fwd_valid_i (wb_we_o),
        .mem_fwd_addr_i  (wb_rd_o),
        .mem_fwd_data_i  (wb_data_o),
        .ex_valid_o      (ex_valid),
        .ex_op_o         (ex_op),
        .ex_rd_o         (ex_rd),
        .ex_opa_o        (ex_opa),
        .ex_opb_o        (ex_opb),
        .ex_cmp_o        (ex_cmp)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en_i   (rf_rd_en),
        .rd_addr_i (rf_rd_addr),
        .rd_data_o (rf_rd_data),
        .wr_en_i   (wb_we_o),
        .wr_addr_i (wb_rd_o),
        .wr_data_i (wb_data_o)
    );

    exec_pipe exec_pipe_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .ex_valid_i     (ex_valid),
        .ex_op_i        (ex_op),
        .ex_rd_i        (ex_rd),
        .ex_opa_i       (ex_opa),
        .ex_opb_i       (ex_opb),
        .ex_cmp_i       (ex_cmp),
        .ex_fwd_valid_o (ex_fwd_valid),
        .ex_fwd_addr_o  (ex_fwd_addr),
        .ex_fwd_data_o  (ex_fwd_data),
        .wb_valid_o     (wb_valid_o),
        .wb_we_o        (wb_we_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_taken_o     (wb_taken_o)
    );

endmodule

// ==== exec_pipe.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module exec_pipe (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          stall_i,
    // From the dispatch register
    input  logic [`ISSUE_LANES-1:0]                       ex_valid_i,
    input  isa_pkg::alu_op_e [`ISSUE_LANES-1:0]           ex_op_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    ex_rd_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_opa_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_opb_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_CMP_W-1:0]     ex_cmp_i,
    // Execute stage bypass
    output logic [`ISSUE_LANES-1:0]                       ex_fwd_valid_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    ex_fwd_addr_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    ex_fwd_data_o,
    // Memory stage, also the bypass and register file write
    output logic [`ISSUE_LANES-1:0]                       wb_valid_o,
    output logic [`ISSUE_LANES-1:0]                       wb_we_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    wb_rd_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    wb_data_o,
    output logic [`ISSUE_LANES-1:0]                       wb_taken_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]  alu_res;
    logic [`ISSUE_LANES-1:0]                     taken;
    logic [`ISSUE_LANES-1:0]                     ex_we;
    logic [`ISSUE_LANES-1:0]                     mem_valid;
    logic [`ISSUE_LANES-1:0]                     mem_we;

    always_comb begin
        for (int l = 0; l < `ISSUE_LANES; l++) begin
            alu_res[l] = '0;
            taken[l]   = 1'b0;
            case (ex_op_i[l])
                OP_ADD:  alu_res[l] = ex_opa_i[l] + ex_opb_i[l];
                OP_SUB:  alu_res[l] = ex_opa_i[l] - ex_opb_i[l];
                OP_AND:  alu_res[l] = ex_opa_i[l] & ex_opb_i[l];
                OP_OR:   alu_res[l] = ex_opa_i[l] | ex_opb_i[l];
                OP_XOR:  alu_res[l] = ex_opa_i[l] ^ ex_opb_i[l];
                // Shift amount is the low 5 bits of operand B
                OP_SLL:  alu_res[l] = ex_opa_i[l] << ex_opb_i[l][4:0];
                OP_SRL:  alu_res[l] = ex_opa_i[l] >> ex_opb_i[l][4:0];
                OP_SLT:  alu_res[l] = {{(`ISSUE_DATA_W-1){1'b0}},
                                       $signed(ex_opa_i[l]) < $signed(ex_opb_i[l])};
                OP_SLTU: alu_res[l] = {{(`ISSUE_DATA_W-1){1'b0}}, ex_opa_i[l] < ex_opb_i[l]};
                OP_BEQ:  taken[l] = ex_cmp_i[l][CMP_EQ];
                OP_BNE:  taken[l] = ex_cmp_i[l][CMP_NE];
                OP_BLT:  taken[l] = ex_cmp_i[l][CMP_LT];
                OP_BGE:  taken[l] = ex_cmp_i[l][CMP_GE];
                OP_BLTU: taken[l] = ex_cmp_i[l][CMP_LTU];
                OP_BGEU: taken[l] = ex_cmp_i[l][CMP_GEU];
                default: alu_res[l] = '0;
            endcase
            // A zero rd means no destination
            ex_we[l] = ex_valid_i[l] && !is_branch(ex_op_i[l]) && ex_rd_i[l] != '0;
        end
    end

    assign ex_fwd_valid_o = ex_we;
    assign ex_fwd_addr_o  = ex_rd_i;
    assign ex_fwd_data_o  = alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= '0;
        end else if (!stall_i) begin
            mem_valid <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_we     <= ex_we;
            wb_rd_o    <= ex_rd_i;
            wb_data_o  <= alu_res;
            wb_taken_o <= taken;
        end
    end

    // Held memory stage reports and writes once the stall lifts
    assign wb_valid_o = mem_valid & {`ISSUE_LANES{~stall_i}};
    assign wb_we_o    = wb_valid_o & mem_we;

endmodule

// ==== dispatch.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module dispatch (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            stall_i,
    input  logic                                            flush_i,
    // Decoded pair with lane 0 as the older one
    input  logic [`ISSUE_LANES-1:0]                         valid_i,
    input  isa_pkg::alu_op_e [`ISSUE_LANES-1:0]             op_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      rj_i,
    input  logic [`ISSUE_LANES-1:0]                         rj_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      rk_i,
    input  logic [`ISSUE_LANES-1:0]                         rk_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      rd_i,
    input  logic [`ISSUE_LANES-1:0]                         rd_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]      imm_i,
    input  logic [`ISSUE_LANES-1:0]                         use_imm_i,
    output logic [`ISSUE_LANES-1:0]                         accept_o,
    // Register file read ports
    output logic [2*`ISSUE_LANES-1:0]                       rf_rd_en_o,
    output logic [2*`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    rf_rd_addr_o,
    input  logic [2*`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    rf_rd_data_i,
    // Bypass from execute and memory stages
    input  logic [`ISSUE_LANES-1:0]                         ex_fwd_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      ex_fwd_addr_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]      ex_fwd_data_i,
    input  logic [`ISSUE_LANES-1:0]                         mem_fwd_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      mem_fwd_addr_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]      mem_fwd_data_i,
    // Dispatch register
    output logic [`ISSUE_LANES-1:0]                         ex_valid_o,
    output isa_pkg::alu_op_e [`ISSUE_LANES-1:0]             ex_op_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]      ex_rd_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]      ex_opa_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]      ex_opb_o,
    output logic [`ISSUE_LANES-1:0][`ISSUE_CMP_W-1:0]       ex_cmp_o
);

    import pipe_pkg::*;

    logic                                            lane1_dep;
    logic [`ISSUE_LANES-1:0]                         issue;
    logic [`ISSUE_LANES-1:0]                         ex_valid_q;
    logic [2*`ISSUE_LANES-1:0]                       src_valid;
    logic [2*`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    opnd;
    fwd_src_e                                        opnd_src [2*`ISSUE_LANES];

    // Lane 1 waits when it reads what lane 0 writes
    assign lane1_dep = rd_valid_i[0] &&
                       ((rj_valid_i[1] && rj_i[1] == rd_i[0]) ||
                        (rk_valid_i[1] && rk_i[1] == rd_i[0]));
    assign issue     = {valid_i[0] & ~lane1_dep, 1'b1};
    assign accept_o  = valid_i & issue & {`ISSUE_LANES{~stall_i & ~flush_i}};

    for (genvar p = 0; p < 2 * `ISSUE_LANES; p++) begin : g_opnd
        // Even ports carry rj and odd ports carry rk
        assign src_valid[p]    = (p % 2 == 0) ? rj_valid_i[p / 2] : rk_valid_i[p / 2];
        assign rf_rd_addr_o[p] = (p % 2 == 0) ? rj_i[p / 2] : rk_i[p / 2];
        // Only read the file when no bypass supplies the operand
        assign rf_rd_en_o[p]   = src_valid[p] && opnd_src[p] == FWD_RF;

        operand_forward operand_forward_inst (
            .rd_valid_i  (src_valid[p]),
            .rd_addr_i   (rf_rd_addr_o[p]),
            .rf_data_i   (rf_rd_data_i[p]),
            .ex_valid_i  (ex_fwd_valid_i),
            .ex_addr_i   (ex_fwd_addr_i),
            .ex_data_i   (ex_fwd_data_i),
            .mem_valid_i (mem_fwd_valid_i),
            .mem_addr_i  (mem_fwd_addr_i),
            .mem_data_i  (mem_fwd_data_i),
            .data_o      (opnd[p]),
            .src_o       (opnd_src[p])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_q <= '0;
        end else if (!stall_i) begin
            // accept_o is already low on flush
            ex_valid_q <= accept_o;
        end
    end

    // A flush squashes the pair in the dispatch register before it executes
    assign ex_valid_o = ex_valid_q & {`ISSUE_LANES{~(flush_i & ~stall_i)}};

    always_ff @(posedge clk) begin
        for (int l = 0; l < `ISSUE_LANES; l++) begin
            if (accept_o[l]) begin
                ex_op_o[l]  <= op_i[l];
                ex_rd_o[l]  <= rd_valid_i[l] ? rd_i[l] : '0;
                ex_opa_o[l] <= opnd[2*l];
                ex_opb_o[l] <= use_imm_i[l] ? imm_i[l] : opnd[2*l+1];
                // Compares always use the two register operands
                ex_cmp_o[l][CMP_EQ]  <= opnd[2*l] == opnd[2*l+1];
                ex_cmp_o[l][CMP_NE]  <= opnd[2*l] != opnd[2*l+1];
                ex_cmp_o[l][CMP_LT]  <= $signed(opnd[2*l]) < $signed(opnd[2*l+1]);
                ex_cmp_o[l][CMP_GE]  <= $signed(opnd[2*l]) >= $signed(opnd[2*l+1]);
                ex_cmp_o[l][CMP_LTU] <= opnd[2*l] < opnd[2*l+1];
                ex_cmp_o[l][CMP_GEU] <= opnd[2*l] >= opnd[2*l+1];
            end
        end
    end

endmodule

// ==== operand_forward.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module operand_forward (
    input  logic                                        rd_valid_i,
    input  logic [`ISSUE_REG_AW-1:0]                    rd_addr_i,
    input  logic [`ISSUE_DATA_W-1:0]                    rf_data_i,
    // Execute stage producers
    input  logic [`ISSUE_LANES-1:0]                     ex_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]  ex_addr_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]  ex_data_i,
    // Memory stage producers
    input  logic [`ISSUE_LANES-1:0]                     mem_valid_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]  mem_addr_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]  mem_data_i,
    output logic [`ISSUE_DATA_W-1:0]                    data_o,
    output pipe_pkg::fwd_src_e                          src_o
);

    import pipe_pkg::*;

    logic [`ISSUE_LANES-1:0] ex_hit;
    logic [`ISSUE_LANES-1:0] mem_hit;

    // A producer of register 0 never matches
    always_comb begin
        for (int l = 0; l < `ISSUE_LANES; l++) begin
            ex_hit[l]  = rd_valid_i && ex_valid_i[l] && ex_addr_i[l] == rd_addr_i &&
                         ex_addr_i[l] != '0;
            mem_hit[l] = rd_valid_i && mem_valid_i[l] && mem_addr_i[l] == rd_addr_i &&
                         mem_addr_i[l] != '0;
        end
    end

    // Newest producer first
    always_comb begin
        if (ex_hit[1]) begin
            src_o = FWD_EX1;
        end else if (ex_hit[0]) begin
            src_o = FWD_EX0;
        end else if (mem_hit[1]) begin
            src_o = FWD_MEM1;
        end else if (mem_hit[0]) begin
            src_o = FWD_MEM0;
        end else begin
            src_o = FWD_RF;
        end
    end

    always_comb begin
        case (src_o)
            FWD_EX1:  data_o = ex_data_i[1];
            FWD_EX0:  data_o = ex_data_i[0];
            FWD_MEM1: data_o = mem_data_i[1];
            FWD_MEM0: data_o = mem_data_i[0];
            default:  data_o = rf_data_i;
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "issue_defs.svh"

module reg_file (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // Read ports, two per lane: 2*lane for rj, 2*lane+1 for rk
    input  logic [2*`ISSUE_LANES-1:0]                     rd_en_i,
    input  logic [2*`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]  rd_addr_i,
    output logic [2*`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]  rd_data_o,
    // One write port per lane
    input  logic [`ISSUE_LANES-1:0]                       wr_en_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_REG_AW-1:0]    wr_addr_i,
    input  logic [`ISSUE_LANES-1:0][`ISSUE_DATA_W-1:0]    wr_data_i
);

    logic [`ISSUE_DATA_W-1:0] regs [`ISSUE_NREGS];

    // Lane 1 is visited last, so it wins a same-address collision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `ISSUE_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `ISSUE_LANES; w++) begin
                if (wr_en_i[w] && wr_addr_i[w] != '0) begin
                    regs[wr_addr_i[w]] <= wr_data_i[w];
                end
            end
        end
    end

    // Asynchronous reads, register 0 is never written and stays zero
    always_comb begin
        for (int p = 0; p < 2 * `ISSUE_LANES; p++) begin
            rd_data_o[p] = rd_en_i[p] ? regs[rd_addr_i[p]] : '0;
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // Bit positions in the branch compare vector
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2,
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4,
        CMP_GEU = 3'd5
    } cmp_bit_e;

    // Operand origin, listed newest first
    typedef enum logic [2:0] {
        FWD_EX1  = 3'd0,
        FWD_EX0  = 3'd1,
        FWD_MEM1 = 3'd2,
        FWD_MEM0 = 3'd3,
        FWD_RF   = 3'd4
    } fwd_src_e;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // ALU and branch opcodes
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SLT  = 4'd7,
        OP_SLTU = 4'd8,
        OP_BEQ  = 4'd9,
        OP_BNE  = 4'd10,
        OP_BLT  = 4'd11,
        OP_BGE  = 4'd12,
        OP_BLTU = 4'd13,
        OP_BGEU = 4'd14
    } alu_op_e;

    // Branches report taken and never write a register
    function automatic logic is_branch(alu_op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

endpackage

// ==== issue_defs.svh ====
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Operand and result width
`define ISSUE_DATA_W 32

// Architectural register file
`define ISSUE_REG_AW 5
`define ISSUE_NREGS 32

// Issue lanes, lane 0 is the older instruction of a pair
`define ISSUE_LANES 2

// Precomputed branch comparisons carried per lane
`define ISSUE_CMP_W 6

`endif
